//--- hdl/vit_consts.svh
// widths and limits are fixed for the rate 1/2, K=3 code with taps 6/7 and are not free knobs
`ifndef VIT_CONSTS_SVH
`define VIT_CONSTS_SVH

// soft input LLR width, signed
`define VIT_LLR_W 4
// branch metric width, holds the sum of two 8-magnitude bit costs
`define VIT_BM_W 5
// modulo state metric width, wraps in long frames
// must stay above twice the worst metric spread
`define VIT_SM_W 7
// trellis size for constraint length 3
`define VIT_STATE_NUM 4
`define VIT_TAG_W 4
// symbols per frame, two tail symbols included
`define VIT_MAX_FRAME 64
// start metric for every state except state 0
`define VIT_SM_INIT 32

`endif

//--- hdl/vit_pkg.sv
// types only; widths come from vit_consts.svh, which must be on the include path
`include "vit_consts.svh"

package vit_pkg;

  //----------------------------------------------------------
  // input side
  //----------------------------------------------------------

  // positive value means code bit 0 is likely
  typedef logic signed [`VIT_LLR_W-1:0] llr_t;

  // one received symbol, llr0 belongs to c0
  typedef struct packed {
    llr_t llr1;
    llr_t llr0;
  } llr_pair_t;

  //----------------------------------------------------------
  // metrics and decisions
  //----------------------------------------------------------

  typedef logic [`VIT_BM_W-1:0] bm_t;
  // indexed by the hypothesis pair {c1, c0}
  typedef bm_t [3:0] bm_vec_t;

  // wraps, compare only through the sign of a difference
  typedef logic [`VIT_SM_W-1:0] sm_t;
  typedef sm_t [`VIT_STATE_NUM-1:0] sm_vec_t;

  // one bit per state, 1 means predecessor {b, 1} survived
  typedef logic [`VIT_STATE_NUM-1:0] decision_t;

  //----------------------------------------------------------
  // framing
  //----------------------------------------------------------

  typedef logic [`VIT_TAG_W-1:0] tag_t;

  typedef struct packed {
    logic sop;
    logic eop;
    tag_t tag;
  } frm_t;

endpackage

//--- hdl/vit_bmu.sv
// one symbol per cycle in, costs one cycle later; frm and bm are only loaded on ival
`timescale 1ns/1ps
`include "vit_consts.svh"

module vit_bmu (
  input  logic               iclk,
  input  logic               ireset,
  input  logic               ival,
  input  vit_pkg::frm_t      ifrm,
  input  vit_pkg::llr_pair_t illr,
  output logic               oval,
  output vit_pkg::frm_t      ofrm,
  output vit_pkg::bm_vec_t   obm
);

  import vit_pkg::*;

  bm_vec_t bm;

  // cost of deciding bit c against one llr
  // c = 1 pays the positive part, c = 0 pays the negative part
  function automatic bm_t bit_cost(input llr_t llr, input logic c);
    logic signed [`VIT_BM_W-1:0] ext;
    bm_t                         cost;
    // sign extend so that -(-8) still fits
    ext = llr;
    if (c) begin
      cost = llr[`VIT_LLR_W-1] ? '0 : bm_t'(ext);
    end
    else begin
      cost = llr[`VIT_LLR_W-1] ? bm_t'(-ext) : '0;
    end
    return cost;
  endfunction

  // hypothesis h carries c0 in bit 0, c1 in bit 1
  always_comb begin
    for (int h = 0; h < 4; h++) begin
      bm[h] = bit_cost(illr.llr0, h[0]) + bit_cost(illr.llr1, h[1]);
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval <= 1'b0;
    end
    else begin
      oval <= ival;
    end
  end

  // payload follows the strobe
  always_ff @(posedge iclk) begin
    if (ival) begin
      ofrm <= ifrm;
      obm  <= bm;
    end
  end

endmodule

//--- hdl/vit_acsu.sv
// single trellis node; predecessor 1 is never state 0, so its load metric is always VIT_SM_INIT
`timescale 1ns/1ps
`include "vit_consts.svh"

module vit_acsu (
  input  logic          iclk,
  input  logic          ireset,
  input  logic          ival,
  input  logic          iload,
  input  vit_pkg::sm_t  iload_value,
  input  vit_pkg::sm_t  ism0,
  input  vit_pkg::sm_t  ism1,
  input  vit_pkg::bm_t  ibm0,
  input  vit_pkg::bm_t  ibm1,
  output vit_pkg::sm_t  osm,
  output logic          odecision
);

  import vit_pkg::*;

  sm_t sm0;
  sm_t sm1;
  sm_t cand0;
  sm_t cand1;
  sm_t diff;

  // frame start, metrics come from the init pattern
  // branch 0 gets the caller's value, branch 1 the common init
  assign sm0 = iload ? iload_value : ism0;
  assign sm1 = iload ? sm_t'(`VIT_SM_INIT) : ism1;

  // add, wraps mod 2^VIT_SM_W
  assign cand0 = sm0 + sm_t'(ibm0);
  assign cand1 = sm1 + sm_t'(ibm1);

  // compare: branch 1 wins only when strictly smaller
  // exact while the true spread stays under half the range
  assign diff      = cand1 - cand0;
  assign odecision = diff[`VIT_SM_W-1];

  // select and hold the survivor
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      osm <= '0;
    end
    else if (ival) begin
      osm <= odecision ? cand1 : cand0;
    end
  end

endmodule

//--- hdl/vit_rp.sv
// trellis routing is fixed to K=3 taps 6/7; metrics restart at every sop
`timescale 1ns/1ps
`include "vit_consts.svh"

module vit_rp (
  input  logic                iclk,
  input  logic                ireset,
  input  logic                ival,
  input  vit_pkg::frm_t       ifrm,
  input  vit_pkg::bm_vec_t    ibm,
  output logic                oval,
  output vit_pkg::frm_t       ofrm,
  output vit_pkg::decision_t  odecision,
  output vit_pkg::sm_vec_t    ostatem
);

  import vit_pkg::*;

  sm_vec_t   sm;
  decision_t dec;
  logic      load;

  // first symbol of a frame starts from the init metrics
  assign load = ival & ifrm.sop;

  //----------------------------------------------------------
  // ACS array
  //----------------------------------------------------------

  // state index s = {u1, u2}, state {a, b} has predecessors {b, 0} and {b, 1}
  // the input bit on both branches into {a, b} is a
  for (genvar gs = 0; gs < `VIT_STATE_NUM; gs++) begin : g_acs
    localparam int a     = gs / 2;
    localparam int b     = gs % 2;
    localparam int pred0 = 2 * b;
    localparam int pred1 = 2 * b + 1;
    // c0 = a ^ u1 on both branches, c1 adds u2
    localparam int c0    = a ^ b;
    localparam int hyp0  = c0 + 2 * c0;
    localparam int hyp1  = c0 + 2 * (1 - c0);
    // predecessor {b, 0} is state 0 only when b is 0
    localparam sm_t load_value = (b == 0) ? sm_t'(0) : sm_t'(`VIT_SM_INIT);

    vit_acsu i_acsu (
      .iclk        ( iclk            ),
      .ireset      ( ireset          ),
      .ival        ( ival            ),
      .iload       ( load            ),
      .iload_value ( load_value      ),
      .ism0        ( sm[pred0]       ),
      .ism1        ( sm[pred1]       ),
      .ibm0        ( ibm[hyp0]       ),
      .ibm1        ( ibm[hyp1]       ),
      .osm         ( sm[gs]          ),
      .odecision   ( dec[gs]         )
    );
  end

  assign ostatem = sm;

  //----------------------------------------------------------
  // output stage, lines up with the metric register
  //----------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval <= 1'b0;
    end
    else begin
      oval <= ival;
    end
  end

  always_ff @(posedge iclk) begin
    if (ival) begin
      ofrm      <= ifrm;
      odecision <= dec;
    end
  end

endmodule

//--- hdl/vit_traceback.sv
// frames of 3 to VIT_MAX_FRAME symbols ending in two zero tail bits; input during busy is not allowed
`timescale 1ns/1ps
`include "vit_consts.svh"

module vit_traceback (
  input  logic               iclk,
  input  logic               ireset,
  input  logic               ival,
  input  vit_pkg::frm_t      ifrm,
  input  vit_pkg::decision_t idecision,
  output logic               oval,
  output logic               osop,
  output logic               oeop,
  output vit_pkg::tag_t      otag,
  output logic               obit,
  output logic               obusy
);

  import vit_pkg::*;

  localparam int addr_w = $clog2(`VIT_MAX_FRAME);

  typedef enum logic [1:0] {
    ph_collect,
    ph_trace,
    ph_emit
  } phase_t;

  phase_t                    phase;
  decision_t                 dec_mem [`VIT_MAX_FRAME];
  logic [`VIT_MAX_FRAME-1:0] bit_buf;
  logic [addr_w-1:0]         wr_ptr;
  logic [addr_w-1:0]         wr_addr;
  logic [addr_w-1:0]         last_idx;
  logic [addr_w-1:0]         last_out;
  logic [addr_w-1:0]         idx;
  logic [1:0]                tb_state;
  logic                      tb_d;
  tag_t                      tag_q;

  //----------------------------------------------------------
  // decision store
  //----------------------------------------------------------

  // sop always lands at address 0
  assign wr_addr = ifrm.sop ? '0 : wr_ptr;

  always_ff @(posedge iclk) begin
    if (ival && phase == ph_collect) begin
      dec_mem[wr_addr] <= idecision;
      if (ifrm.sop) begin
        tag_q <= ifrm.tag;
      end
    end
  end

  // survivor bit of the state being traced
  assign tb_d = dec_mem[idx][tb_state];

  // last emitted bit, the two tail bits are dropped
  assign last_out = last_idx - 2'd2;

  assign otag = tag_q;

  //----------------------------------------------------------
  // bit buffer, filled backwards and read forwards
  //----------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (phase == ph_trace) begin
      // decoded input bit is the state MSB
      bit_buf[idx] <= tb_state[1];
    end
    if (phase == ph_emit) begin
      obit <= bit_buf[idx];
    end
  end

  //----------------------------------------------------------
  // phase control
  //----------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      phase    <= ph_collect;
      wr_ptr   <= '0;
      last_idx <= '0;
      idx      <= '0;
      tb_state <= '0;
      oval     <= 1'b0;
      osop     <= 1'b0;
      oeop     <= 1'b0;
      obusy    <= 1'b0;
    end
    else begin
      oval <= 1'b0;
      osop <= 1'b0;
      oeop <= 1'b0;
      // busy from the first stored symbol until one cycle after eop out
      if (ival) begin
        obusy <= 1'b1;
      end
      else if (oeop) begin
        obusy <= 1'b0;
      end
      case (phase)
        ph_collect: begin
          if (ival) begin
            wr_ptr <= wr_addr + 1'b1;
            // terminated frame, trace starts in state 0
            if (ifrm.eop) begin
              last_idx <= wr_addr;
              idx      <= wr_addr;
              tb_state <= '0;
              phase    <= ph_trace;
            end
          end
        end
        ph_trace: begin
          // step to predecessor {b, d}
          tb_state <= {tb_state[0], tb_d};
          if (idx == '0) begin
            phase <= ph_emit;
          end
          else begin
            idx <= idx - 1'b1;
          end
        end
        ph_emit: begin
          oval <= 1'b1;
          osop <= (idx == '0);
          oeop <= (idx == last_out);
          if (idx == last_out) begin
            phase <= ph_collect;
          end
          else begin
            idx <= idx + 1'b1;
          end
        end
        default: begin
          phase <= ph_collect;
        end
      endcase
    end
  end

endmodule

//--- hdl/vit_dec.sv
// no back-pressure; a new frame may start only after obusy has fallen
`timescale 1ns/1ps

module vit_dec (
  input  logic               iclk,
  input  logic               ireset,
  input  logic               ival,
  input  vit_pkg::frm_t      ifrm,
  input  vit_pkg::llr_pair_t illr,
  output logic               oval,
  output logic               osop,
  output logic               oeop,
  output vit_pkg::tag_t      otag,
  output logic               obit,
  output logic               obusy
);

  import vit_pkg::*;

  logic      bmu_val;
  frm_t      bmu_frm;
  bm_vec_t   bmu_bm;
  logic      rp_val;
  frm_t      rp_frm;
  decision_t rp_decision;
  logic      tb_busy;

  vit_bmu i_bmu (
    .iclk   ( iclk    ),
    .ireset ( ireset  ),
    .ival   ( ival    ),
    .ifrm   ( ifrm    ),
    .illr   ( illr    ),
    .oval   ( bmu_val ),
    .ofrm   ( bmu_frm ),
    .obm    ( bmu_bm  )
  );

  // metrics stay internal, visible only for debug
  vit_rp i_rp (
    .iclk      ( iclk        ),
    .ireset    ( ireset      ),
    .ival      ( bmu_val     ),
    .ifrm      ( bmu_frm     ),
    .ibm       ( bmu_bm      ),
    .oval      ( rp_val      ),
    .ofrm      ( rp_frm      ),
    .odecision ( rp_decision ),
    .ostatem   (             )
  );

  vit_traceback i_tb (
    .iclk      ( iclk        ),
    .ireset    ( ireset      ),
    .ival      ( rp_val      ),
    .ifrm      ( rp_frm      ),
    .idecision ( rp_decision ),
    .oval      ( oval        ),
    .osop      ( osop        ),
    .oeop      ( oeop        ),
    .otag      ( otag        ),
    .obit      ( obit        ),
    .obusy     ( tb_busy     )
  );

  // symbols still in the pipe count as busy too
  assign obusy = tb_busy | bmu_val | rp_val;

endmodule

//--- dv/vit_model.svh
// reference decoder for taps 6/7 with unbounded integer metrics; reads llr0_a/llr1_a of the including module
`ifndef VIT_MODEL_SVH
`define VIT_MODEL_SVH

// ------------------------------------------------------------
// branch cost
// ------------------------------------------------------------

// hypothesis bit 1 pays the positive part, bit 0 the negative part
function automatic int llr_cost(input int llr, input bit c);
  int cost;
  if (c) begin
    cost = (llr > 0) ? llr : 0;
  end
  else begin
    cost = (llr < 0) ? -llr : 0;
  end
  return cost;
endfunction

// ------------------------------------------------------------
// trellis walk and traceback
// ------------------------------------------------------------

// fills model_bits[0 .. n_sym-1], counts ties, tracks the largest metric
task automatic run_model(input int n_sym);
  int       sm [4];
  int       nsm [4];
  bit [3:0] dec [`VIT_MAX_FRAME];
  bit       a;
  bit       b;
  int       m0;
  int       m1;
  int       st;
  // encoder starts in state 0, all other states start behind
  sm[0] = 0;
  for (int s = 1; s < 4; s++) begin
    sm[s] = `VIT_SM_INIT;
  end
  for (int k = 0; k < n_sym; k++) begin
    for (int s = 0; s < 4; s++) begin
      // state {a, b}: a is the new bit, b the previous one
      a = s[1];
      b = s[0];
      // via {b, 0}: c0 = c1 = a^b
      m0 = sm[2*b] + llr_cost(llr0_a[k], a ^ b) + llr_cost(llr1_a[k], a ^ b);
      // via {b, 1}: c1 picks up u2 = 1
      m1 = sm[2*b+1] + llr_cost(llr0_a[k], a ^ b) + llr_cost(llr1_a[k], !(a ^ b));
      if (m0 == m1) begin
        tie_count++;
      end
      // tie keeps branch 0
      dec[k][s] = (m1 < m0);
      nsm[s]    = dec[k][s] ? m1 : m0;
      if (nsm[s] > metric_peak) begin
        metric_peak = nsm[s];
      end
    end
    for (int s = 0; s < 4; s++) begin
      sm[s] = nsm[s];
    end
  end
  // terminated frame so the trace starts from state 0
  st = 0;
  for (int k = n_sym - 1; k >= 0; k--) begin
    model_bits[k] = st[1];
    st = (st % 2) * 2 + int'(dec[k][st]);
  end
endtask

`endif

//--- dv/vit_dec_tb.sv
// one frame in flight at a time, next frame only after busy drops; fixed seed stimulus
`timescale 1ns/1ps
`include "vit_consts.svh"

module vit_dec_tb;

  import vit_pkg::*;

  // kinds rotate clean / noisy / max length with heavy noise
  localparam int frame_num   = 30;
  localparam int out_timeout = 4 * `VIT_MAX_FRAME + 20;

  logic      iclk;
  logic      ireset;
  logic      ival;
  frm_t      ifrm;
  llr_pair_t illr;
  logic      oval;
  logic      osop;
  logic      oeop;
  tag_t      otag;
  logic      obit;
  logic      obusy;

  integer seed;
  int     llr0_a [`VIT_MAX_FRAME];
  int     llr1_a [`VIT_MAX_FRAME];
  bit     info_a [`VIT_MAX_FRAME];
  bit     model_bits [`VIT_MAX_FRAME];
  bit     exp_bits [`VIT_MAX_FRAME];
  int     tie_count;
  int     metric_peak;

  `include "vit_model.svh"

  vit_dec i_dut (
    .iclk   ( iclk   ),
    .ireset ( ireset ),
    .ival   ( ival   ),
    .ifrm   ( ifrm   ),
    .illr   ( illr   ),
    .oval   ( oval   ),
    .osop   ( osop   ),
    .oeop   ( oeop   ),
    .otag   ( otag   ),
    .obit   ( obit   ),
    .obusy  ( obusy  )
  );

  // 100 ns period
  always #50 iclk = ~iclk;

  // ------------------------------------------------------------
  // checking
  // ------------------------------------------------------------

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected) begin
      stop_on_error($sformatf("mismatch %s: got 0x%0h, expected 0x%0h",
                              name, actual, expected));
    end
  endtask

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  // code bit 0 leans positive, 1 negative
  function automatic int code_llr(input bit c, input int kind);
    int v;
    if (kind == 2) begin
      v = c ? -8 : 7;
    end
    else begin
      v = c ? -rand_range(1, 8) : rand_range(1, 7);
    end
    // sign flips, -8 has no positive twin so it becomes 7
    if (kind == 1 && rand_range(0, 7) == 0) begin
      v = (v == -8) ? 7 : -v;
    end
    else if (kind == 1 && rand_range(0, 15) == 0) begin
      // erased symbol, source of ties
      v = 0;
    end
    else if (kind == 2 && rand_range(0, 7) < 3) begin
      v = (v == -8) ? 7 : -v;
    end
    return v;
  endfunction

  // random info bits, two zero tail bits, rate 1/2 encoder
  task automatic build_frame(input int n_info, input int kind);
    bit u;
    bit u1;
    bit u2;
    u1 = 1'b0;
    u2 = 1'b0;
    for (int k = 0; k < n_info + 2; k++) begin
      u = (k < n_info) ? (rand_range(0, 1) == 1) : 1'b0;
      info_a[k] = u;
      // c0 from taps 110, c1 from taps 111
      llr0_a[k] = code_llr(u ^ u1, kind);
      llr1_a[k] = code_llr(u ^ u1 ^ u2, kind);
      u2 = u1;
      u1 = u;
    end
  endtask

  task automatic drive_frame(input int n_sym, input tag_t tag);
    frm_t      frm;
    llr_pair_t pair;
    for (int k = 0; k < n_sym; k++) begin
      frm.sop   = (k == 0);
      frm.eop   = (k == n_sym - 1);
      frm.tag   = tag;
      pair.llr0 = llr_t'(llr0_a[k]);
      pair.llr1 = llr_t'(llr1_a[k]);
      @(posedge iclk);
      ival <= 1'b1;
      ifrm <= frm;
      illr <= pair;
      @(negedge iclk);
      // busy shows one cycle after the first symbol
      compare_value("obusy", obusy, k > 0);
      compare_value("oval", oval, 1'b0);
    end
    @(posedge iclk);
    ival <= 1'b0;
    ifrm <= '0;
    illr <= '0;
  endtask

  // ------------------------------------------------------------
  // response
  // ------------------------------------------------------------

  task automatic collect_frame(input int n_info, input tag_t tag);
    int count;
    int cycles;
    count  = 0;
    cycles = 0;
    while (count < n_info) begin
      @(negedge iclk);
      cycles++;
      if (cycles > out_timeout) begin
        stop_on_error("timeout: decoded bits of the frame did not all arrive");
      end
      compare_value("obusy", obusy, 1'b1);
      if (oval) begin
        compare_value("osop", osop, count == 0);
        compare_value("oeop", oeop, count == n_info - 1);
        compare_value("otag", otag, tag);
        compare_value("obit", obit, exp_bits[count]);
        count++;
      end
    end
    // busy drops the cycle after eop, no stray bits
    @(negedge iclk);
    compare_value("obusy", obusy, 1'b0);
    compare_value("oval", oval, 1'b0);
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------

  initial begin
    int   n_info;
    int   kind;
    tag_t tag;
    iclk        = 1'b0;
    ireset      = 1'b1;
    ival        = 1'b0;
    ifrm        = '0;
    illr        = '0;
    seed        = 62991;
    tie_count   = 0;
    metric_peak = 0;
    for (int i = 0; i < 16; i++) begin
      @(posedge iclk);
    end
    ireset <= 1'b0;
    // quiet outputs before any input
    for (int i = 0; i < 4; i++) begin
      @(negedge iclk);
      compare_value("oval", oval, 1'b0);
      compare_value("osop", osop, 1'b0);
      compare_value("oeop", oeop, 1'b0);
      compare_value("obusy", obusy, 1'b0);
    end
    for (int f = 0; f < frame_num; f++) begin
      kind   = f % 3;
      n_info = (kind == 2) ? `VIT_MAX_FRAME - 2 : rand_range(4, `VIT_MAX_FRAME - 2);
      tag    = tag_t'(rand_range(0, 15));
      build_frame(n_info, kind);
      run_model(n_info + 2);
      // clean frames must give back the sent bits
      for (int k = 0; k < n_info; k++) begin
        exp_bits[k] = (kind == 0) ? info_a[k] : model_bits[k];
      end
      drive_frame(n_info + 2, tag);
      collect_frame(n_info, tag);
    end
    // heavy frames have to push metrics past the modulo range
    if (metric_peak < (1 << `VIT_SM_W) || tie_count == 0) begin
      stop_on_error("stimulus never wrapped the state metrics or never hit a tie");
    end
    else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

//--- src.f
+incdir+hdl
+incdir+dv
hdl/vit_pkg.sv
hdl/vit_bmu.sv
hdl/vit_acsu.sv
hdl/vit_rp.sv
hdl/vit_traceback.sv
hdl/vit_dec.sv
dv/vit_dec_tb.sv
